// File: Makefile
# sources named in the file list, plus the shared header
SRCS := $(filter-out +%,$(shell cat verilog.f)) rv_config.svh

obj_dir/Vtb_rv_core: $(SRCS) verilog.f
	verilator --binary --timing --assert -j 0 --top-module tb_rv_core -f verilog.f

.PHONY: run clean

run: obj_dir/Vtb_rv_core
	@out="$$(./obj_dir/Vtb_rv_core)"; echo "$$out"; echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

// File: rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data and address width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NUM_REGS 32

// first fetch address
`define RV_RESET_PC 32'h0000_0000

// pc advance for a fall-through instruction
`define RV_PC_STEP 4

`endif

// File: rv_core.sv
`timescale 1ns/10ps

module rv_core
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_enable,

    input  rv_core_pkg::rv_word_t i_mem_data,

    output logic                  o_mem_write_en,
    output rv_core_pkg::rv_word_t o_mem_addr,
    output rv_core_pkg::rv_word_t o_mem_data,

    output logic                  o_is_halted
);

import rv_core_pkg::*;
import rv_isa_pkg::*;

rv_word_t        w_pc;
logic            w_capture;
logic            w_exec_strobe;
logic            w_load_wb_strobe;
rv_decoded_t     w_decoded;
rv_exec_result_t w_result;

rv_sequencer u_sequencer
(
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_enable         (i_enable),
    .i_result         (w_result),
    .o_pc             (w_pc),
    .o_capture        (w_capture),
    .o_exec_strobe    (w_exec_strobe),
    .o_load_wb_strobe (w_load_wb_strobe),
    .o_mem_write_en   (o_mem_write_en),
    .o_mem_addr       (o_mem_addr),
    .o_mem_data       (o_mem_data),
    .o_is_halted      (o_is_halted)
);

// instruction word arrives on the shared read port
rv_decode_buffer u_decode_buffer
(
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_capture  (w_capture),
    .i_mem_data (i_mem_data),
    .o_decoded  (w_decoded)
);

rv_execute u_execute
(
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_exec_strobe    (w_exec_strobe),
    .i_load_wb_strobe (w_load_wb_strobe),
    .i_pc             (w_pc),
    .i_mem_data       (i_mem_data),
    .i_decoded        (w_decoded),
    .o_result         (w_result)
);

endmodule

// File: rv_core_checker.sv
`timescale 1ns/10ps

module rv_core_checker
(
    input logic                  i_clk,
    input logic                  i_rst,
    input logic                  i_mem_write_en,
    input rv_core_pkg::rv_word_t i_mem_addr,
    input logic                  i_is_halted
);

import rv_core_pkg::*;

// halt is left only through reset
halt_sticky: assert property (@(posedge i_clk)
    i_is_halted |=> (i_is_halted || $past(i_rst)))
    else $error("o_is_halted fell without a reset");

halt_no_write: assert property (@(posedge i_clk)
    i_is_halted |-> !i_mem_write_en)
    else $error("o_mem_write_en is high while halted");

reset_values: assert property (@(posedge i_clk)
    $past(i_rst) |-> (!i_mem_write_en && (i_mem_addr == rv_word_t'(0)) && !i_is_halted))
    else $error("core outputs not at reset values after reset");

endmodule

bind rv_core rv_core_checker u_checker
(
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_mem_write_en (o_mem_write_en),
    .i_mem_addr     (o_mem_addr),
    .i_is_halted    (o_is_halted)
);

// File: rv_core_pkg.sv
`include "rv_config.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0] rv_word_t;
    typedef logic [$clog2(`RV_NUM_REGS)-1:0] rv_reg_idx_t;

    // one instruction walks through these steps
    typedef enum logic [2:0]
    {
        st_init,
        st_fetch,
        st_fetch_wait,
        st_decode,
        st_execute,
        st_load_wait,
        st_load_wb,
        st_halt
    } rv_seq_state_t;

    typedef struct packed
    {
        logic     valid;
        logic     write;
        rv_word_t addr;
        rv_word_t wdata;
    } rv_mem_req_t;

    typedef struct packed
    {
        rv_word_t    next_pc;
        rv_mem_req_t mem_req;
        logic        load_pending;
        logic        illegal;
    } rv_exec_result_t;

endpackage

// File: rv_decode_buffer.sv
`timescale 1ns/10ps

module rv_decode_buffer
(
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     i_capture,
    input  rv_core_pkg::rv_word_t    i_mem_data,
    output rv_isa_pkg::rv_decoded_t  o_decoded
);

import rv_core_pkg::*;
import rv_isa_pkg::*;

rv_word_t   r_inst;

rv_funct3_t w_funct3;
logic [6:0] w_funct7;
rv_word_t   w_imm_i;
rv_word_t   w_imm_s;
rv_word_t   w_imm_b;
rv_word_t   w_imm_u;
rv_word_t   w_imm_j;
rv_word_t   w_imm;
logic       w_valid;

// an all-zero word decodes as illegal
always_ff @(posedge i_clk)
begin
    if (i_rst)
        r_inst <= '0;
    else if (i_capture)
        r_inst <= i_mem_data;
end

assign w_funct3 = r_inst[14:12];
assign w_funct7 = r_inst[31:25];

assign w_imm_i = {{20{r_inst[31]}}, r_inst[31:20]};
assign w_imm_s = {{20{r_inst[31]}}, r_inst[31:25], r_inst[11:7]};
assign w_imm_b = {{19{r_inst[31]}}, r_inst[31], r_inst[7], r_inst[30:25], r_inst[11:8], 1'b0};
assign w_imm_u = {r_inst[31:12], 12'b0};
assign w_imm_j = {{11{r_inst[31]}}, r_inst[31], r_inst[19:12], r_inst[20], r_inst[30:21], 1'b0};

always_comb
begin
    w_valid = 1'b0;
    w_imm   = w_imm_i;
    case (r_inst[6:0])
        opc_lui,
        opc_auipc:
        begin
            w_valid = 1'b1;
            w_imm   = w_imm_u;
        end
        opc_jal:
        begin
            w_valid = 1'b1;
            w_imm   = w_imm_j;
        end
        opc_jalr:
            w_valid = (w_funct3 == 3'b000);
        opc_branch:
        begin
            w_valid = w_funct3 inside {f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
            w_imm   = w_imm_b;
        end
        opc_load:
            w_valid = (w_funct3 == f3_mem_word);
        opc_store:
        begin
            w_valid = (w_funct3 == f3_mem_word);
            w_imm   = w_imm_s;
        end
        opc_op_imm:
        begin
            // shift amounts sit in the immediate, upper bits must be funct7
            if (w_funct3 == f3_sll)
                w_valid = (w_funct7 == f7_base);
            else if (w_funct3 == f3_srl)
                w_valid = (w_funct7 == f7_base) || (w_funct7 == f7_alt);
            else
                w_valid = 1'b1;
        end
        opc_op:
        begin
            if ((w_funct3 == f3_add) || (w_funct3 == f3_srl))
                w_valid = (w_funct7 == f7_base) || (w_funct7 == f7_alt);
            else
                w_valid = (w_funct7 == f7_base);
        end
        default:
            w_valid = 1'b0;
    endcase
end

always_comb
begin
    o_decoded.opcode = rv_opcode_e'(r_inst[6:0]);
    o_decoded.rd     = r_inst[11:7];
    o_decoded.rs1    = r_inst[19:15];
    o_decoded.rs2    = r_inst[24:20];
    o_decoded.funct3 = w_funct3;
    o_decoded.alt    = r_inst[30];
    o_decoded.imm    = w_imm;
    o_decoded.valid  = w_valid;
end

endmodule

// File: rv_execute.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_execute
(
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic                         i_exec_strobe,
    input  logic                         i_load_wb_strobe,
    input  rv_core_pkg::rv_word_t        i_pc,
    input  rv_core_pkg::rv_word_t        i_mem_data,
    input  rv_isa_pkg::rv_decoded_t      i_decoded,
    output rv_core_pkg::rv_exec_result_t o_result
);

import rv_core_pkg::*;
import rv_isa_pkg::*;

// x0 has no storage
rv_word_t    r_regs [1:`RV_NUM_REGS-1];

rv_reg_idx_t w_rd;
rv_word_t    w_rs1_val;
rv_word_t    w_rs2_val;
rv_word_t    w_alu_b;
logic [$clog2(`RV_XLEN)-1:0] w_shamt;
rv_word_t    w_alu;
logic        w_take;
rv_word_t    w_pc_plus;
rv_word_t    w_pc_target;
rv_word_t    w_jalr_target;
rv_word_t    w_eff_addr;
rv_word_t    w_next_pc;
rv_word_t    w_wr_data;
logic        w_wr_en;
rv_mem_req_t w_mem_req;
logic        w_load;

assign w_rd      = i_decoded.rd;
assign w_rs1_val = (i_decoded.rs1 == '0) ? '0 : r_regs[i_decoded.rs1];
assign w_rs2_val = (i_decoded.rs2 == '0) ? '0 : r_regs[i_decoded.rs2];

assign w_alu_b = (i_decoded.opcode == opc_op) ? w_rs2_val : i_decoded.imm;
assign w_shamt = w_alu_b[$clog2(`RV_XLEN)-1:0];

always_comb
begin
    w_alu = '0;
    case (i_decoded.funct3)
        f3_add:
            // addi has no subtract form, bit 30 is part of its immediate
            if ((i_decoded.opcode == opc_op) && i_decoded.alt)
                w_alu = w_rs1_val - w_alu_b;
            else
                w_alu = w_rs1_val + w_alu_b;
        f3_sll:
            w_alu = w_rs1_val << w_shamt;
        f3_slt:
            w_alu = rv_word_t'($signed(w_rs1_val) < $signed(w_alu_b));
        f3_sltu:
            w_alu = rv_word_t'(w_rs1_val < w_alu_b);
        f3_xor:
            w_alu = w_rs1_val ^ w_alu_b;
        f3_srl:
            if (i_decoded.alt)
                w_alu = rv_word_t'($signed(w_rs1_val) >>> w_shamt);
            else
                w_alu = w_rs1_val >> w_shamt;
        f3_or:
            w_alu = w_rs1_val | w_alu_b;
        f3_and:
            w_alu = w_rs1_val & w_alu_b;
        default:
            w_alu = '0;
    endcase
end

// branch compare
always_comb
begin
    case (i_decoded.funct3)
        f3_beq:  w_take = (w_rs1_val == w_rs2_val);
        f3_bne:  w_take = (w_rs1_val != w_rs2_val);
        f3_blt:  w_take = ($signed(w_rs1_val) < $signed(w_rs2_val));
        f3_bge:  w_take = ($signed(w_rs1_val) >= $signed(w_rs2_val));
        f3_bltu: w_take = (w_rs1_val < w_rs2_val);
        f3_bgeu: w_take = (w_rs1_val >= w_rs2_val);
        default: w_take = 1'b0;
    endcase
end

assign w_pc_plus     = i_pc + `RV_PC_STEP;
assign w_pc_target   = i_pc + i_decoded.imm;
assign w_eff_addr    = w_rs1_val + i_decoded.imm;
assign w_jalr_target = {w_eff_addr[`RV_XLEN-1:1], 1'b0};

always_comb
begin
    w_next_pc = w_pc_plus;
    w_wr_data = w_alu;
    w_wr_en   = 1'b0;
    w_mem_req = '0;
    w_load    = 1'b0;
    case (i_decoded.opcode)
        opc_lui:
        begin
            w_wr_data = i_decoded.imm;
            w_wr_en   = 1'b1;
        end
        opc_auipc:
        begin
            w_wr_data = w_pc_target;
            w_wr_en   = 1'b1;
        end
        opc_jal:
        begin
            w_wr_data = w_pc_plus;
            w_wr_en   = 1'b1;
            w_next_pc = w_pc_target;
        end
        opc_jalr:
        begin
            w_wr_data = w_pc_plus;
            w_wr_en   = 1'b1;
            w_next_pc = w_jalr_target;
        end
        opc_branch:
            if (w_take)
                w_next_pc = w_pc_target;
        opc_load:
        begin
            w_mem_req.valid = 1'b1;
            w_mem_req.addr  = w_eff_addr;
            w_load          = 1'b1;
        end
        opc_store:
        begin
            w_mem_req.valid = 1'b1;
            w_mem_req.write = 1'b1;
            w_mem_req.addr  = w_eff_addr;
            w_mem_req.wdata = w_rs2_val;
        end
        opc_op_imm,
        opc_op:
            w_wr_en = 1'b1;
        default:
            w_wr_en = 1'b0;
    endcase
end

always_ff @(posedge i_clk)
begin
    if (i_rst)
    begin
        for (int i = 1; i < `RV_NUM_REGS; i++)
            r_regs[i] <= '0;
    end
    else if (i_exec_strobe && w_wr_en && (w_rd != '0))
        r_regs[w_rd] <= w_wr_data;
    else if (i_load_wb_strobe && (w_rd != '0))
        r_regs[w_rd] <= i_mem_data;
end

always_comb
begin
    o_result.next_pc      = w_next_pc;
    o_result.mem_req      = w_mem_req;
    o_result.load_pending = w_load;
    o_result.illegal      = !i_decoded.valid;
end

endmodule

// File: rv_isa_pkg.sv
package rv_isa_pkg;

    typedef logic [2:0] rv_funct3_t;

    // major opcodes kept by this core
    typedef enum logic [6:0]
    {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011
    } rv_opcode_e;

    typedef enum logic [2:0]
    {
        f3_add  = 3'b000,
        f3_sll  = 3'b001,
        f3_slt  = 3'b010,
        f3_sltu = 3'b011,
        f3_xor  = 3'b100,
        f3_srl  = 3'b101,
        f3_or   = 3'b110,
        f3_and  = 3'b111
    } rv_alu_f3_e;

    typedef enum logic [2:0]
    {
        f3_beq  = 3'b000,
        f3_bne  = 3'b001,
        f3_blt  = 3'b100,
        f3_bge  = 3'b101,
        f3_bltu = 3'b110,
        f3_bgeu = 3'b111
    } rv_branch_f3_e;

    // only full word accesses remain
    typedef enum logic [2:0]
    {
        f3_mem_word = 3'b010
    } rv_mem_f3_e;

    // alt selects sub and sra/srai
    typedef enum logic [6:0]
    {
        f7_base = 7'b0000000,
        f7_alt  = 7'b0100000
    } rv_funct7_e;

    typedef struct packed
    {
        rv_opcode_e               opcode;
        rv_core_pkg::rv_reg_idx_t rd;
        rv_core_pkg::rv_reg_idx_t rs1;
        rv_core_pkg::rv_reg_idx_t rs2;
        rv_funct3_t               funct3;
        logic                     alt;
        rv_core_pkg::rv_word_t    imm;
        logic                     valid;
    } rv_decoded_t;

endpackage

// File: rv_sequencer.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_sequencer
(
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic                         i_enable,

    input  rv_core_pkg::rv_exec_result_t i_result,
    output rv_core_pkg::rv_word_t        o_pc,

    output logic                         o_capture,
    output logic                         o_exec_strobe,
    output logic                         o_load_wb_strobe,

    output logic                         o_mem_write_en,
    output rv_core_pkg::rv_word_t        o_mem_addr,
    output rv_core_pkg::rv_word_t        o_mem_data,

    output logic                         o_is_halted
);

import rv_core_pkg::*;

rv_seq_state_t r_state;
rv_word_t      r_pc;

assign o_pc = r_pc;

// strobes only fire on enabled cycles so a frozen core repeats nothing
assign o_capture        = i_enable && (r_state == st_decode);
assign o_exec_strobe    = i_enable && (r_state == st_execute);
assign o_load_wb_strobe = i_enable && (r_state == st_load_wb);

assign o_is_halted = (r_state == st_halt);

always_ff @(posedge i_clk)
begin
    if (i_rst)
    begin
        r_state        <= st_init;
        r_pc           <= `RV_RESET_PC;
        o_mem_write_en <= 1'b0;
        o_mem_addr     <= '0;
    end
    else if (i_enable)
    begin
        case (r_state)
            st_init:
                r_state <= st_fetch;
            st_fetch:
            begin
                // also ends the write of a store from the previous instruction
                o_mem_write_en <= 1'b0;
                o_mem_addr     <= r_pc;
                r_state        <= st_fetch_wait;
            end
            st_fetch_wait:
                r_state <= st_decode;
            st_decode:
                r_state <= st_execute;
            st_execute:
            begin
                if (i_result.illegal)
                    r_state <= st_halt;
                else
                begin
                    r_pc <= i_result.next_pc;
                    if (i_result.mem_req.valid)
                    begin
                        o_mem_write_en <= i_result.mem_req.write;
                        o_mem_addr     <= i_result.mem_req.addr;
                    end
                    r_state <= i_result.load_pending ? st_load_wait : st_fetch;
                end
            end
            st_load_wait:
                r_state <= st_load_wb;
            st_load_wb:
                r_state <= st_fetch;
            default:
                r_state <= st_halt;
        endcase
    end
end

// store data
always_ff @(posedge i_clk)
begin
    if (o_exec_strobe && !i_result.illegal && i_result.mem_req.valid)
        o_mem_data <= i_result.mem_req.wdata;
end

endmodule

// File: tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;

import rv_core_pkg::*;

localparam int clk_period    = 40;
localparam int reset_cycles  = 8;
localparam int freeze_cycles = 12;
localparam int settle_cycles = 20;
localparam int num_tests     = 5;
// instruction words of all five programs, terminators included
localparam int total_instr   = 124;
localparam int watchdog_cycles = total_instr * 6 + num_tests * (reset_cycles + 12)
                                 + freeze_cycles + settle_cycles + 200;

localparam int op_lui    = 'h37;
localparam int op_auipc  = 'h17;
localparam int op_jalr   = 'h67;
localparam int op_load   = 'h03;
localparam int op_op_imm = 'h13;

logic     i_clk;
logic     i_rst;
logic     i_enable;
rv_word_t i_mem_data = '0;
logic     o_mem_write_en;
rv_word_t o_mem_addr;
rv_word_t o_mem_data;
logic     o_is_halted;

rv_word_t mem      [0:255];
rv_word_t image    [0:255];
rv_word_t snapshot [0:255];
logic [7:0] read_addr = '0;
logic       load_req  = 1'b0;

rv_word_t lfsr = 32'h95665a6d;
rv_word_t prog[$];
int       slot_addr[$];
rv_word_t slot_expect[$];
int       next_slot;
string    test_name;
int       test_errors  = 0;
int       total_errors = 0;
int       tests_run    = 0;
int       tests_failed = 0;

rv_core i_rv_core
(
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_enable       (i_enable),
    .i_mem_data     (i_mem_data),
    .o_mem_write_en (o_mem_write_en),
    .o_mem_addr     (o_mem_addr),
    .o_mem_data     (o_mem_data),
    .o_is_halted    (o_is_halted)
);

initial
begin
    i_clk = 1'b0;
    forever #(clk_period / 2) i_clk = ~i_clk;
end

// word memory, one cycle read latency, low address bits ignored
always @(posedge i_clk)
begin
    if (load_req)
    begin
        for (int k = 0; k < 256; k++)
            mem[8'(k)] <= image[8'(k)];
    end
    else if (o_mem_write_en)
        mem[o_mem_addr[9:2]] <= o_mem_data;
    read_addr <= o_mem_addr[9:2];
end

always @(negedge i_clk)
    i_mem_data <= mem[read_addr];

function automatic logic lfsr_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b)
        lfsr = lfsr ^ 32'h8020_0003;
    return b;
endfunction

function automatic rv_word_t random_bits(int n);
    rv_word_t v;
    v = '0;
    for (int k = 0; k < n; k++)
        v = {v[30:0], lfsr_bit()};
    return v;
endfunction

// opcode 7f in the low byte keeps fill words illegal
function automatic rv_word_t fill_word(int k);
    return {k[7:0], ~k[7:0], k[7:0], 8'hff};
endfunction

function automatic rv_word_t r_format(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
endfunction

function automatic rv_word_t i_format(int imm, int rs1, int f3, int rd, int opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
endfunction

function automatic rv_word_t s_format(int imm, int rs2, int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
endfunction

function automatic rv_word_t b_format(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
endfunction

function automatic rv_word_t u_format(int imm, int rd, int opc);
    return {imm[19:0], rd[4:0], opc[6:0]};
endfunction

function automatic rv_word_t j_format(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
endfunction

// reference results from the RV32I rules
function automatic rv_word_t op_rule(int f3, logic alt, rv_word_t a, rv_word_t b);
    case (f3)
        0: return alt ? a - b : a + b;
        1: return a << b[4:0];
        2: return rv_word_t'($signed(a) < $signed(b));
        3: return rv_word_t'(a < b);
        4: return a ^ b;
        5: return alt ? rv_word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        6: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_rule(int f3, rv_word_t a, rv_word_t b);
    case (f3)
        0: return a == b;
        1: return a != b;
        4: return $signed(a) < $signed(b);
        5: return $signed(a) >= $signed(b);
        6: return a < b;
        default: return a >= b;
    endcase
endfunction

task automatic note_failure();
    test_errors++;
    total_errors++;
endtask

task automatic check_value(string name, rv_word_t got, rv_word_t expected);
    if (got !== expected)
    begin
        $display("error: %s is %h, expected %h", name, got, expected);
        note_failure();
    end
endtask

task automatic begin_test(string name);
    test_name = name;
    test_errors = 0;
    prog.delete();
    slot_addr.delete();
    slot_expect.delete();
    next_slot = 128;
endtask

task automatic end_test();
    tests_run++;
    if (test_errors == 0)
        $display("test %s: ok", test_name);
    else
    begin
        tests_failed++;
        $display("test %s: %0d errors", test_name, test_errors);
    end
endtask

task automatic emit(rv_word_t word);
    prog.push_back(word);
endtask

// lui and addi, upper part rounded for the sign of the low part
task automatic load_const(int rd, rv_word_t v);
    rv_word_t hi;
    hi = (v + 32'h800) >> 12;
    emit(u_format(int'(hi), rd, op_lui));
    emit(i_format(int'(v[11:0]), rd, 0, rd, op_op_imm));
endtask

task automatic store_result(int rd, rv_word_t expected);
    emit(s_format(next_slot * 4, rd, 0));
    slot_addr.push_back(next_slot);
    slot_expect.push_back(expected);
    next_slot++;
endtask

task automatic start_program();
    for (int k = 0; k < 256; k++)
    begin
        if (k < prog.size())
            image[8'(k)] = prog[k];
        else if (k == prog.size())
            image[8'(k)] = '0;
        else
            image[8'(k)] = fill_word(k);
    end
    @(negedge i_clk);
    i_enable = 1'b1;
    i_rst = 1'b1;
    load_req = 1'b1;
    @(negedge i_clk);
    load_req = 1'b0;
    repeat (reset_cycles - 1) @(negedge i_clk);
    i_rst = 1'b0;
endtask

task automatic wait_halt(int limit);
    int cycles;
    cycles = 0;
    while (!o_is_halted && cycles < limit)
    begin
        @(negedge i_clk);
        cycles++;
    end
    if (!o_is_halted)
    begin
        $display("core did not halt within %0d cycles in test %s", limit, test_name);
        note_failure();
    end
endtask

task automatic check_slots();
    for (int k = 0; k < slot_addr.size(); k++)
        check_value($sformatf("mem[%0d]", slot_addr[k]), mem[8'(slot_addr[k])], slot_expect[k]);
endtask

task automatic run_and_check();
    start_program();
    wait_halt(prog.size() * 6 + 10);
    check_slots();
endtask

task automatic reset_state();
    begin_test("reset_state");
    emit(i_format(int'(random_bits(12)), 0, 0, 5, op_op_imm));
    start_program();
    check_value("o_mem_write_en", {31'b0, o_mem_write_en}, 32'h0);
    check_value("o_is_halted", {31'b0, o_is_halted}, 32'h0);
    check_value("o_mem_addr", o_mem_addr, 32'h0);
    // init, fetch, then the memory samples the fetch address
    repeat (3) @(negedge i_clk);
    check_value("memory read address", {22'b0, read_addr, 2'b00}, 32'h0);
    wait_halt(prog.size() * 6 + 10);
    end_test();
endtask

task automatic alu_ops();
    rv_word_t a;
    rv_word_t b;
    rv_word_t imm_val;
    int       imm;
    begin_test("alu_ops");
    a = random_bits(32);
    b = random_bits(32);
    load_const(1, a);
    load_const(2, b);
    for (int f3 = 0; f3 < 8; f3++)
        for (int alt = 0; alt < 2; alt++)
            if (alt == 0 || f3 == 0 || f3 == 5)
            begin
                emit(r_format(alt * 32, 2, 1, f3, 3));
                store_result(3, op_rule(f3, alt == 1, a, b));
            end
    for (int f3 = 0; f3 < 8; f3++)
        for (int alt = 0; alt < 2; alt++)
            if (alt == 0 || f3 == 5)
            begin
                // shifts carry funct7 in the upper immediate bits
                if (f3 == 1 || f3 == 5)
                    imm = alt * 1024 + int'(random_bits(5));
                else
                    imm = int'(random_bits(12));
                imm_val = {{20{imm[11]}}, imm[11:0]};
                emit(i_format(imm, 1, f3, 4, op_op_imm));
                store_result(4, op_rule(f3, alt == 1, a, imm_val));
            end
    run_and_check();
    end_test();
endtask

task automatic branch_jump();
    rv_word_t a;
    rv_word_t b;
    int       rs1;
    int       rs2;
    int       pc;
    int       target;
    begin_test("branch_jump");
    a = random_bits(32);
    b = random_bits(32);
    if (b == a)
        b = a ^ 32'd1;
    load_const(1, a);
    load_const(2, b);
    for (int f3 = 0; f3 < 8; f3++)
        for (int swap = 0; swap < 2; swap++)
            if (f3 != 2 && f3 != 3)
            begin
                // equal pair for beq and bne, swapped pair for the compares
                rs1 = (f3 >= 4 && swap == 1) ? 2 : 1;
                rs2 = (f3 < 2) ? (swap == 1 ? 2 : 1) : (swap == 1 ? 1 : 2);
                emit(i_format(1, 0, 0, 6, op_op_imm));
                emit(b_format(8, rs2, rs1, f3));
                emit(i_format(2, 0, 0, 6, op_op_imm));
                store_result(6, branch_rule(f3, rs1 == 1 ? a : b, rs2 == 1 ? a : b)
                                ? 32'd1 : 32'd2);
            end
    emit(i_format('h55, 0, 0, 8, op_op_imm));
    pc = prog.size() * 4;
    emit(j_format(8, 7));
    emit(i_format('h66, 0, 0, 8, op_op_imm));
    store_result(7, rv_word_t'(pc + 4));
    target = (prog.size() + 3) * 4;
    emit(i_format(target, 0, 0, 9, op_op_imm));
    pc = prog.size() * 4;
    // odd offset, bit 0 of the target is dropped
    emit(i_format(1, 9, 0, 10, op_jalr));
    emit(i_format('h77, 0, 0, 8, op_op_imm));
    store_result(10, rv_word_t'(pc + 4));
    store_result(8, 32'h55);
    run_and_check();
    end_test();
endtask

task automatic load_store();
    rv_word_t r;
    int       imm20;
    int       pc;
    begin_test("load_store");
    r = random_bits(32);
    load_const(1, r);
    store_result(1, r);
    emit(i_format((next_slot - 1) * 4, 0, 2, 2, op_load));
    store_result(2, r);
    imm20 = int'(random_bits(20));
    pc = prog.size() * 4;
    emit(u_format(imm20, 3, op_auipc));
    store_result(3, rv_word_t'(pc) + (rv_word_t'(imm20) << 12));
    emit(u_format(int'(random_bits(20)), 0, op_lui));
    emit(i_format(int'(random_bits(12)), 1, 0, 0, op_op_imm));
    store_result(0, 32'h0);
    run_and_check();
    end_test();
endtask

task automatic halt_freeze();
    rv_word_t r;
    rv_word_t held;
    int       skip_slot;
    begin_test("halt_freeze");
    r = random_bits(32);
    load_const(1, r);
    store_result(1, r);
    emit(32'hffff_ffff);
    // behind the illegal word, never executed
    skip_slot = next_slot;
    emit(s_format(skip_slot * 4, 1, 0));
    slot_addr.push_back(skip_slot);
    slot_expect.push_back(fill_word(skip_slot));
    start_program();
    repeat (5) @(negedge i_clk);
    i_enable = 1'b0;
    held = o_mem_addr;
    repeat (freeze_cycles)
    begin
        @(negedge i_clk);
        check_value("o_mem_addr", o_mem_addr, held);
    end
    i_enable = 1'b1;
    wait_halt(prog.size() * 6 + 10);
    for (int k = 0; k < 256; k++)
        snapshot[8'(k)] = mem[8'(k)];
    repeat (settle_cycles)
    begin
        @(negedge i_clk);
        check_value("o_mem_write_en", {31'b0, o_mem_write_en}, 32'h0);
    end
    for (int k = 0; k < 256; k++)
        check_value($sformatf("mem[%0d]", k), mem[8'(k)], snapshot[8'(k)]);
    check_slots();
    end_test();
endtask

initial
begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired before the tests finished");
    $display("Some tests failed");
    $finish;
end

initial
begin
    i_rst = 1'b1;
    i_enable = 1'b1;
    reset_state();
    alu_ops();
    branch_jump();
    load_store();
    halt_freeze();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
    if (total_errors == 0)
        $display("All tests passed");
    else
        $display("Some tests failed");
    $finish;
end

endmodule

// File: verilog.f
+incdir+.
rv_core_pkg.sv
rv_isa_pkg.sv
rv_sequencer.sv
rv_decode_buffer.sv
rv_execute.sv
rv_core.sv
rv_core_checker.sv
tb_rv_core.sv
